// File: logic/ex_settings.svh
////////////////////
// Execute stage settings
// Data width, register index width and multiplier iteration count
////////////////////

`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Integer data word width
`define EX_XLEN 32

// Register file index width
`define EX_REG_ADDR_W 5

// Shift-add iterations, one product bit per cycle
`define EX_MUL_STEPS `EX_XLEN

`endif

// File: logic/ex_pkg.sv
////////////////////
// Execute stage package
// Word types and the operation and state encodings
////////////////////

`include "ex_settings.svh"

package ex_pkg;

  // One operand or result word
  typedef logic [`EX_XLEN-1:0] word_t;

  // Destination register index
  typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

  // ALU operations, the last six are branch compares
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Multiply modes, low word or high word by signedness
  typedef enum logic [1:0] {
    MUL_LO,
    MUL_HI_SS,
    MUL_HI_SU,
    MUL_HI_UU
  } mul_op_e;

  // Multiplier sequencer
  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_BUSY,
    MUL_DONE
  } mul_state_e;

endpackage

// File: logic/ex_issue_if.sv
////////////////////
// Issue bus inside the execute stage
// Carries the gated instruction to the units and the output side
////////////////////

`timescale 1ns/100ps

interface ex_issue_if;

  // Present and neither killed nor halted
  logic               instr_valid;

  // ALU request
  ex_pkg::alu_op_e    alu_op;
  ex_pkg::word_t      operand_a;
  ex_pkg::word_t      operand_b;

  // Multiplier request
  logic               mul_en;
  ex_pkg::mul_op_e    mul_op;

  // Register file write and instruction address
  logic               rf_we;
  ex_pkg::reg_addr_t  rf_waddr;
  ex_pkg::word_t      pc;

  // Input side drives everything
  modport issue (output instr_valid, alu_op, operand_a, operand_b,
                 output mul_en, mul_op, rf_we, rf_waddr, pc);

  modport alu (input alu_op, operand_a, operand_b);

  modport mult (input instr_valid, mul_en, mul_op, operand_a, operand_b);

  // Output side sees the whole instruction
  modport retire (input instr_valid, alu_op, operand_a, operand_b,
                  input mul_en, mul_op, rf_we, rf_waddr, pc);

endinterface

// File: logic/ex_issue.sv
////////////////////
// Execute stage input side
// Applies kill and halt, decides when the stage accepts and completes
////////////////////

`timescale 1ns/100ps

module ex_issue (
  input  logic               clk,
  input  logic               rst_n,

  // Instruction from decode
  input  logic               instr_valid_i,
  input  logic               kill_i,
  input  logic               halt_i,
  input  ex_pkg::alu_op_e    alu_op_i,
  input  ex_pkg::word_t      operand_a_i,
  input  ex_pkg::word_t      operand_b_i,
  input  logic               mul_en_i,
  input  ex_pkg::mul_op_e    mul_op_i,
  input  logic               rf_we_i,
  input  ex_pkg::reg_addr_t  rf_waddr_i,
  input  ex_pkg::word_t      pc_i,

  // Unit and writeback status
  input  logic               mul_valid_i,
  input  logic               mul_ready_i,
  input  logic               wb_ready_i,

  // Stage handshake levels
  output logic               ex_valid_o,
  output logic               ex_ready_o,

  ex_issue_if.issue          issue
);

  // Kill and halt both suppress the instruction
  assign issue.instr_valid = instr_valid_i && !kill_i && !halt_i;

  // Payload passes to the units unchanged
  assign issue.alu_op    = alu_op_i;
  assign issue.operand_a = operand_a_i;
  assign issue.operand_b = operand_b_i;
  assign issue.mul_en    = mul_en_i;
  assign issue.mul_op    = mul_op_i;
  assign issue.rf_we     = rf_we_i;
  assign issue.rf_waddr  = rf_waddr_i;
  assign issue.pc        = pc_i;

  // ALU finishes at once, a multiply waits for its result
  assign ex_valid_o = issue.instr_valid && (!mul_en_i || mul_valid_i);

  // A killed instruction leaves right away
  // otherwise wait for writeback and the multiplier, unless halted
  assign ex_ready_o = kill_i || (wb_ready_i && mul_ready_i && !halt_i);

  ////////////////////
  // Checks
  ////////////////////

  // Nothing reaches writeback in a kill cycle, even with a finished multiply
  a_no_valid_on_kill : assert property (
    @(posedge clk) disable iff (!rst_n)
    kill_i |-> !ex_valid_o
  );

endmodule

// File: logic/ex_alu.sv
////////////////////
// Single-cycle ALU
// Arithmetic, logic, shifts, set-less-than and branch compares
////////////////////

`timescale 1ns/100ps

module ex_alu (
  ex_issue_if.alu        alu,

  output ex_pkg::word_t  result_o,
  output logic           cmp_result_o
);

  ex_pkg::word_t  op_a;
  ex_pkg::word_t  op_b;
  logic [4:0]     shamt;

  // Shared comparator outputs
  logic           is_equal;
  logic           less_signed;
  logic           less_unsigned;

  ex_pkg::word_t  sum;
  ex_pkg::word_t  diff;

  assign op_a  = alu.operand_a;
  assign op_b  = alu.operand_b;

  // Shift amount from the low five bits of operand b
  assign shamt = op_b[4:0];

  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  assign is_equal      = (op_a == op_b);
  assign less_signed   = ($signed(op_a) < $signed(op_b));
  assign less_unsigned = (op_a < op_b);

  ////////////////////
  // Branch compare
  ////////////////////

  always_comb begin
    unique case (alu.alu_op)
      ex_pkg::ALU_EQ:  cmp_result_o = is_equal;
      ex_pkg::ALU_NE:  cmp_result_o = !is_equal;
      ex_pkg::ALU_LT:  cmp_result_o = less_signed;
      ex_pkg::ALU_GE:  cmp_result_o = !less_signed;
      ex_pkg::ALU_LTU: cmp_result_o = less_unsigned;
      ex_pkg::ALU_GEU: cmp_result_o = !less_unsigned;
      // Not a branch
      default:         cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////
  // Result select
  ////////////////////

  always_comb begin
    unique case (alu.alu_op)
      ex_pkg::ALU_ADD:  result_o = sum;
      ex_pkg::ALU_SUB:  result_o = diff;
      ex_pkg::ALU_AND:  result_o = op_a & op_b;
      ex_pkg::ALU_OR:   result_o = op_a | op_b;
      ex_pkg::ALU_XOR:  result_o = op_a ^ op_b;
      ex_pkg::ALU_SLL:  result_o = op_a << shamt;
      ex_pkg::ALU_SRL:  result_o = op_a >> shamt;
      // Arithmetic shift keeps the sign bit
      ex_pkg::ALU_SRA:  result_o = ex_pkg::word_t'($signed(op_a) >>> shamt);
      ex_pkg::ALU_SLT:  result_o = ex_pkg::word_t'(less_signed);
      ex_pkg::ALU_SLTU: result_o = ex_pkg::word_t'(less_unsigned);
      // Compares give the decision zero-extended
      ex_pkg::ALU_EQ,
      ex_pkg::ALU_NE,
      ex_pkg::ALU_LT,
      ex_pkg::ALU_GE,
      ex_pkg::ALU_LTU,
      ex_pkg::ALU_GEU:  result_o = ex_pkg::word_t'(cmp_result_o);
      default:          result_o = sum;
    endcase
  end

endmodule

// File: logic/ex_mult.sv
////////////////////
// Sequential shift-add multiplier
// Signed modes, one product bit per cycle, valid/ready result
////////////////////

`timescale 1ns/100ps

`include "ex_settings.svh"

module ex_mult (
  input  logic           clk,
  input  logic           rst_n,

  ex_issue_if.mult       mult,

  input  logic           kill_i,
  input  logic           wb_ready_i,

  output ex_pkg::word_t  result_o,
  output logic           valid_o,
  output logic           ready_o
);

  localparam int unsigned CNT_W = $clog2(`EX_MUL_STEPS);

  ex_pkg::mul_state_e        state_q;
  logic [CNT_W-1:0]          step_q;

  // Operand payload, loaded at start
  logic [2*`EX_XLEN-1:0]     prod_q;
  ex_pkg::word_t             mcand_q;
  logic                      neg_q;
  ex_pkg::mul_op_e           op_q;

  logic                      start;
  logic                      a_signed;
  logic                      b_signed;
  logic                      a_neg;
  logic                      b_neg;
  ex_pkg::word_t             a_mag;
  ex_pkg::word_t             b_mag;
  logic [`EX_XLEN:0]         partial;
  logic [2*`EX_XLEN-1:0]     prod_signed;

  assign start = (state_q == ex_pkg::MUL_IDLE) && mult.instr_valid && mult.mul_en;

  // Low word is the same for any signedness
  assign a_signed = (mult.mul_op == ex_pkg::MUL_HI_SS) || (mult.mul_op == ex_pkg::MUL_HI_SU);
  assign b_signed = (mult.mul_op == ex_pkg::MUL_HI_SS);
  assign a_neg    = a_signed && mult.operand_a[`EX_XLEN-1];
  assign b_neg    = b_signed && mult.operand_b[`EX_XLEN-1];
  assign a_mag    = a_neg ? -mult.operand_a : mult.operand_a;
  assign b_mag    = b_neg ? -mult.operand_b : mult.operand_b;

  // Add multiplicand into the high half when the current multiplier bit is set
  assign partial = {1'b0, prod_q[2*`EX_XLEN-1:`EX_XLEN]} +
                   (prod_q[0] ? {1'b0, mcand_q} : '0);

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::MUL_IDLE;
      step_q  <= '0;
    end else begin
      unique case (state_q)
        ex_pkg::MUL_IDLE: begin
          step_q <= '0;
          if (start) state_q <= ex_pkg::MUL_BUSY;
        end
        ex_pkg::MUL_BUSY: begin
          step_q <= step_q + 1'b1;
          if (kill_i) state_q <= ex_pkg::MUL_IDLE;
          else if (step_q == CNT_W'(`EX_MUL_STEPS - 1)) state_q <= ex_pkg::MUL_DONE;
        end
        ex_pkg::MUL_DONE: begin
          // Result held until writeback takes it
          if (kill_i || wb_ready_i) state_q <= ex_pkg::MUL_IDLE;
        end
        default: state_q <= ex_pkg::MUL_IDLE;
      endcase
    end
  end

  // Datapath, multiplier in the low half shifts out as the product shifts in
  always_ff @(posedge clk) begin
    if (start) begin
      prod_q  <= {{`EX_XLEN{1'b0}}, b_mag};
      mcand_q <= a_mag;
      neg_q   <= a_neg ^ b_neg;
      op_q    <= mult.mul_op;
    end else if (state_q == ex_pkg::MUL_BUSY) begin
      prod_q  <= {partial, prod_q[`EX_XLEN-1:1]};
    end
  end

  // Restore sign, then pick the requested word
  assign prod_signed = neg_q ? -prod_q : prod_q;
  assign result_o    = (op_q == ex_pkg::MUL_LO) ? prod_signed[`EX_XLEN-1:0]
                                                : prod_signed[2*`EX_XLEN-1:`EX_XLEN];

  assign valid_o = (state_q == ex_pkg::MUL_DONE);
  assign ready_o = ((state_q == ex_pkg::MUL_IDLE) && !start) ||
                   ((state_q == ex_pkg::MUL_DONE) && wb_ready_i);

  // Result must not move under writeback back-pressure
  a_result_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (valid_o && !wb_ready_i) |=> $stable(result_o)
  );

endmodule

// File: logic/ex_retire.sv
////////////////////
// Execute stage output side
// Result select for forwarding and the EX/WB pipeline register
////////////////////

`timescale 1ns/100ps

module ex_retire (
  input  logic               clk,
  input  logic               rst_n,

  ex_issue_if.retire         retire,

  // Unit results
  input  ex_pkg::word_t      alu_result_i,
  input  ex_pkg::word_t      mul_result_i,
  input  logic               cmp_result_i,

  // Stage handshake
  input  logic               ex_valid_i,
  input  logic               wb_ready_i,

  // Forwarding toward decode
  output ex_pkg::word_t      rf_wdata_o,

  // EX/WB register
  output logic               wb_valid_o,
  output logic               wb_rf_we_o,
  output ex_pkg::reg_addr_t  wb_rf_waddr_o,
  output ex_pkg::word_t      wb_rf_wdata_o,
  output ex_pkg::word_t      wb_pc_o,
  output logic               wb_branch_taken_o
);

  // Write data mux, harmless for invalid instructions since rf_we is qualified later
  assign rf_wdata_o = retire.mul_en ? mul_result_i : alu_result_i;

  ////////////////////
  // EX/WB register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o        <= 1'b0;
      wb_rf_we_o        <= 1'b0;
      wb_rf_waddr_o     <= '0;
      wb_rf_wdata_o     <= '0;
      wb_pc_o           <= '0;
      wb_branch_taken_o <= 1'b0;
    end else begin
      if (ex_valid_i && wb_ready_i) begin
        wb_valid_o        <= 1'b1;
        wb_rf_we_o        <= retire.rf_we;
        wb_pc_o           <= retire.pc;
        wb_branch_taken_o <= cmp_result_i;
        // Destination and data only move for real writes
        if (retire.rf_we) begin
          wb_rf_waddr_o <= retire.rf_waddr;
          wb_rf_wdata_o <= rf_wdata_o;
        end
      end else if (wb_ready_i) begin
        // Writeback free but nothing finished, insert a bubble
        wb_valid_o <= 1'b0;
      end
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // A stalled entry stays in the register
  a_wb_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    (wb_valid_o && !wb_ready_i) |=> wb_valid_o
  );

endmodule

// File: logic/ex_stage.sv
////////////////////
// Execute stage top level
// ALU, multiplier and EX/WB register behind plain ports
////////////////////

`timescale 1ns/100ps

module ex_stage (
  input  logic               clk,
  input  logic               rst_n,

  // Decoded instruction
  input  logic               instr_valid_i,
  input  ex_pkg::alu_op_e    alu_op_i,
  input  ex_pkg::word_t      operand_a_i,
  input  ex_pkg::word_t      operand_b_i,
  input  ex_pkg::word_t      operand_c_i,
  input  logic               mul_en_i,
  input  ex_pkg::mul_op_e    mul_op_i,
  input  logic               rf_we_i,
  input  ex_pkg::reg_addr_t  rf_waddr_i,
  input  ex_pkg::word_t      pc_i,

  // Controller levels
  input  logic               kill_i,
  input  logic               halt_i,

  // Forwarding and branch to fetch
  output ex_pkg::word_t      rf_wdata_o,
  output logic               branch_decision_o,
  output ex_pkg::word_t      branch_target_o,

  // Stage handshake
  output logic               ex_valid_o,
  output logic               ex_ready_o,
  input  logic               wb_ready_i,

  // EX/WB register
  output logic               wb_valid_o,
  output logic               wb_rf_we_o,
  output ex_pkg::reg_addr_t  wb_rf_waddr_o,
  output ex_pkg::word_t      wb_rf_wdata_o,
  output ex_pkg::word_t      wb_pc_o,
  output logic               wb_branch_taken_o
);

  ex_pkg::word_t  alu_result;
  logic           alu_cmp_result;
  ex_pkg::word_t  mul_result;
  logic           mul_valid;
  logic           mul_ready;

  ex_issue_if issue_bus ();

  // Branch target computed in decode
  assign branch_target_o   = operand_c_i;
  assign branch_decision_o = alu_cmp_result;

  ex_issue i_issue (
    .clk, .rst_n, .instr_valid_i, .kill_i, .halt_i, .alu_op_i, .operand_a_i, .operand_b_i,
    .mul_en_i, .mul_op_i, .rf_we_i, .rf_waddr_i, .pc_i,
    .mul_valid_i (mul_valid), .mul_ready_i (mul_ready), .wb_ready_i,
    .ex_valid_o, .ex_ready_o, .issue (issue_bus.issue)
  );

  ex_alu i_alu (.alu (issue_bus.alu), .result_o (alu_result), .cmp_result_o (alu_cmp_result));

  ex_mult i_mult (
    .clk, .rst_n, .mult (issue_bus.mult), .kill_i, .wb_ready_i,
    .result_o (mul_result), .valid_o (mul_valid), .ready_o (mul_ready)
  );

  ex_retire i_retire (
    .clk, .rst_n, .retire (issue_bus.retire),
    .alu_result_i (alu_result), .mul_result_i (mul_result), .cmp_result_i (alu_cmp_result),
    .ex_valid_i (ex_valid_o), .wb_ready_i, .rf_wdata_o,
    .wb_valid_o, .wb_rf_we_o, .wb_rf_waddr_o, .wb_rf_wdata_o, .wb_pc_o, .wb_branch_taken_o
  );

endmodule

// File: test/tb_ex_stage.sv
////////////////////
// Execute stage testbench
// Table of ALU, multiply, kill and halt cases under random writeback stalls
////////////////////

`timescale 1ns/100ps

`include "ex_settings.svh"

module tb_ex_stage;

  localparam int MAX_STALL = 4;

  // Control flag per entry
  localparam int CTRL_NONE = 0;
  localparam int CTRL_KILL = 1;
  localparam int CTRL_HALT = 2;

  typedef struct {
    ex_pkg::alu_op_e    op;
    ex_pkg::word_t      a;
    ex_pkg::word_t      b;
    logic               mul_en;
    ex_pkg::mul_op_e    mul_op;
    logic               rf_we;
    ex_pkg::reg_addr_t  waddr;
    int                 ctrl;
    ex_pkg::word_t      exp_res;
    logic               exp_br;
  } entry_t;

  logic               clk;
  logic               rst_n;
  logic               instr_valid_i;
  ex_pkg::alu_op_e    alu_op_i;
  ex_pkg::word_t      operand_a_i;
  ex_pkg::word_t      operand_b_i;
  ex_pkg::word_t      operand_c_i;
  logic               mul_en_i;
  ex_pkg::mul_op_e    mul_op_i;
  logic               rf_we_i;
  ex_pkg::reg_addr_t  rf_waddr_i;
  ex_pkg::word_t      pc_i;
  logic               kill_i;
  logic               halt_i;
  logic               wb_ready_i;

  ex_pkg::word_t      rf_wdata_o;
  logic               branch_decision_o;
  ex_pkg::word_t      branch_target_o;
  logic               ex_valid_o;
  logic               ex_ready_o;
  logic               wb_valid_o;
  logic               wb_rf_we_o;
  ex_pkg::reg_addr_t  wb_rf_waddr_o;
  ex_pkg::word_t      wb_rf_wdata_o;
  ex_pkg::word_t      wb_pc_o;
  logic               wb_branch_taken_o;

  entry_t             table_q[$];
  bit                 table_ready;
  int                 errors;
  int                 entries_failed;

  // Last written register and data, expected to survive rf_we low
  ex_pkg::word_t      last_wdata;
  ex_pkg::reg_addr_t  last_waddr;

  ex_stage i_ex_stage (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string name, input ex_pkg::word_t got, input ex_pkg::word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input ex_pkg::reg_addr_t got,
                            input ex_pkg::reg_addr_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic add_entry(input ex_pkg::alu_op_e op, input ex_pkg::word_t a,
                           input ex_pkg::word_t b, input logic mul_en,
                           input ex_pkg::mul_op_e mul_op, input logic rf_we,
                           input ex_pkg::reg_addr_t waddr, input int ctrl,
                           input ex_pkg::word_t exp_res, input logic exp_br);
    entry_t e;
    e = '{op, a, b, mul_en, mul_op, rf_we, waddr, ctrl, exp_res, exp_br};
    table_q.push_back(e);
  endtask

  task automatic build_table();
    // ALU operations
    add_entry(ex_pkg::ALU_ADD, 32'h5, 32'h7, 0, ex_pkg::MUL_LO, 1, 5'd1, CTRL_NONE, 32'hC, 0);
    add_entry(ex_pkg::ALU_SUB, 32'h3, 32'h5, 0, ex_pkg::MUL_LO, 1, 5'd2, CTRL_NONE,
              32'hFFFF_FFFE, 0);
    add_entry(ex_pkg::ALU_AND, 32'hF0F0_1234, 32'h0FF0_FF00, 0, ex_pkg::MUL_LO, 1, 5'd3,
              CTRL_NONE, 32'h00F0_1200, 0);
    add_entry(ex_pkg::ALU_OR, 32'hF000_0000, 32'h0000_000F, 0, ex_pkg::MUL_LO, 1, 5'd4,
              CTRL_NONE, 32'hF000_000F, 0);
    add_entry(ex_pkg::ALU_XOR, 32'hFFFF_0000, 32'h0F0F_0F0F, 0, ex_pkg::MUL_LO, 1, 5'd5,
              CTRL_NONE, 32'hF0F0_0F0F, 0);
    // Shift amount takes only the low five bits
    add_entry(ex_pkg::ALU_SLL, 32'h1, 32'h24, 0, ex_pkg::MUL_LO, 1, 5'd6, CTRL_NONE, 32'h10, 0);
    add_entry(ex_pkg::ALU_SRL, 32'h8000_0000, 32'd31, 0, ex_pkg::MUL_LO, 1, 5'd7, CTRL_NONE,
              32'h1, 0);
    add_entry(ex_pkg::ALU_SRA, 32'h8000_0000, 32'd4, 0, ex_pkg::MUL_LO, 1, 5'd8, CTRL_NONE,
              32'hF800_0000, 0);
    add_entry(ex_pkg::ALU_SLT, 32'hFFFF_FFFF, 32'h1, 0, ex_pkg::MUL_LO, 1, 5'd9, CTRL_NONE,
              32'h1, 0);
    add_entry(ex_pkg::ALU_SLTU, 32'hFFFF_FFFF, 32'h1, 0, ex_pkg::MUL_LO, 1, 5'd10, CTRL_NONE,
              32'h0, 0);
    // Branch compares, no register write
    add_entry(ex_pkg::ALU_EQ, 32'h5, 32'h5, 0, ex_pkg::MUL_LO, 0, 5'd11, CTRL_NONE, 32'h1, 1);
    add_entry(ex_pkg::ALU_NE, 32'h5, 32'h5, 0, ex_pkg::MUL_LO, 0, 5'd12, CTRL_NONE, 32'h0, 0);
    add_entry(ex_pkg::ALU_LT, 32'hFFFF_FFFE, 32'h2, 0, ex_pkg::MUL_LO, 0, 5'd13, CTRL_NONE,
              32'h1, 1);
    add_entry(ex_pkg::ALU_GE, 32'hFFFF_FFFE, 32'h2, 0, ex_pkg::MUL_LO, 0, 5'd14, CTRL_NONE,
              32'h0, 0);
    add_entry(ex_pkg::ALU_LTU, 32'hFFFF_FFFE, 32'h2, 0, ex_pkg::MUL_LO, 0, 5'd15, CTRL_NONE,
              32'h0, 0);
    add_entry(ex_pkg::ALU_GEU, 32'hFFFF_FFFE, 32'h2, 0, ex_pkg::MUL_LO, 0, 5'd16, CTRL_NONE,
              32'h1, 1);
    // Multiplies, -3 times 7 and friends
    add_entry(ex_pkg::ALU_ADD, 32'hFFFF_FFFD, 32'h7, 1, ex_pkg::MUL_LO, 1, 5'd17, CTRL_NONE,
              32'hFFFF_FFEB, 0);
    add_entry(ex_pkg::ALU_ADD, 32'hFFFF_FFFD, 32'h7, 1, ex_pkg::MUL_HI_SS, 1, 5'd18, CTRL_NONE,
              32'hFFFF_FFFF, 0);
    add_entry(ex_pkg::ALU_ADD, 32'hFFFF_FFFD, 32'h8000_0000, 1, ex_pkg::MUL_HI_SU, 1, 5'd19,
              CTRL_NONE, 32'hFFFF_FFFE, 0);
    add_entry(ex_pkg::ALU_ADD, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1, ex_pkg::MUL_HI_UU, 1, 5'd20,
              CTRL_NONE, 32'hFFFF_FFFE, 0);
    add_entry(ex_pkg::ALU_ADD, 32'h8000_0000, 32'h8000_0000, 1, ex_pkg::MUL_HI_SS, 1, 5'd21,
              CTRL_NONE, 32'h4000_0000, 0);
    add_entry(ex_pkg::ALU_ADD, 32'h1234_5678, 32'h10, 1, ex_pkg::MUL_LO, 0, 5'd22, CTRL_NONE,
              32'h2345_6780, 0);
    // Kill and halt
    add_entry(ex_pkg::ALU_ADD, 32'h1, 32'h1, 0, ex_pkg::MUL_LO, 1, 5'd23, CTRL_KILL, 32'h2, 0);
    add_entry(ex_pkg::ALU_ADD, 32'h9, 32'h9, 1, ex_pkg::MUL_LO, 1, 5'd24, CTRL_KILL, 32'h51, 0);
    add_entry(ex_pkg::ALU_ADD, 32'h100, 32'h23, 0, ex_pkg::MUL_LO, 1, 5'd25, CTRL_HALT,
              32'h123, 0);
    add_entry(ex_pkg::ALU_ADD, 32'h6, 32'h7, 1, ex_pkg::MUL_LO, 1, 5'd26, CTRL_HALT, 32'h2A, 0);
  endtask

  task automatic drive_entry(input entry_t e, input int idx);
    instr_valid_i = 1'b1;
    alu_op_i      = e.op;
    operand_a_i   = e.a;
    operand_b_i   = e.b;
    pc_i          = 32'h1000 + idx * 4;
    // Branch target from decode, offset from the pc
    operand_c_i   = pc_i + 32'h80;
    mul_en_i      = e.mul_en;
    mul_op_i      = e.mul_op;
    rf_we_i       = e.rf_we;
    rf_waddr_i    = e.waddr;
  endtask

  // Killed instruction must leave no trace in writeback
  task automatic run_kill(input entry_t e, input int idx);
    kill_i     = 1'b0;
    wb_ready_i = 1'b1;
    drive_entry(e, idx);
    if (e.mul_en) begin
      // Let the multiplier get busy first
      repeat (5) begin
        @(negedge clk);
        check_flag("ex_valid_o", ex_valid_o, 1'b0);
      end
    end
    kill_i = 1'b1;
    #1;
    check_flag("ex_valid_o", ex_valid_o, 1'b0);
    check_flag("ex_ready_o", ex_ready_o, 1'b1);
    @(negedge clk);
    kill_i        = 1'b0;
    instr_valid_i = 1'b0;
    repeat (3) begin
      check_flag("wb_valid_o", wb_valid_o, 1'b0);
      @(negedge clk);
    end
  endtask

  // Normal completion with a random stall before writeback takes the result
  task automatic run_normal(input entry_t e, input int idx);
    int                 waited;
    int                 stall;
    logic               hold_valid;
    ex_pkg::word_t      hold_wdata;
    ex_pkg::word_t      hold_pc;
    ex_pkg::reg_addr_t  hold_waddr;
    waited = 0;
    stall  = 1 + $urandom % MAX_STALL;
    wb_ready_i = 1'b0;
    drive_entry(e, idx);
    hold_valid = wb_valid_o;
    hold_wdata = wb_rf_wdata_o;
    hold_pc    = wb_pc_o;
    hold_waddr = wb_rf_waddr_o;
    #1;
    while (!ex_valid_o && waited < `EX_MUL_STEPS + 8) begin
      @(negedge clk);
      waited++;
    end
    if (!ex_valid_o) begin
      $display("Entry %0d never raised ex_valid_o", idx);
      errors++;
    end
    check_word("rf_wdata_o", rf_wdata_o, e.exp_res);
    check_flag("branch_decision_o", branch_decision_o, e.exp_br);
    check_word("branch_target_o", branch_target_o, pc_i + 32'h80);
    repeat (stall) begin
      @(negedge clk);
      check_flag("ex_ready_o", ex_ready_o, 1'b0);
      check_flag("ex_valid_o", ex_valid_o, 1'b1);
      check_word("rf_wdata_o", rf_wdata_o, e.exp_res);
    end
    // Outputs held while writeback was stalled
    check_flag("wb_valid_o", wb_valid_o, hold_valid);
    check_word("wb_rf_wdata_o", wb_rf_wdata_o, hold_wdata);
    check_word("wb_pc_o", wb_pc_o, hold_pc);
    check_addr("wb_rf_waddr_o", wb_rf_waddr_o, hold_waddr);
    wb_ready_i = 1'b1;
    #1;
    check_flag("ex_ready_o", ex_ready_o, 1'b1);
    @(negedge clk);
    instr_valid_i = 1'b0;
    if (e.rf_we) begin
      last_wdata = e.exp_res;
      last_waddr = e.waddr;
    end
    check_flag("wb_valid_o", wb_valid_o, 1'b1);
    check_flag("wb_rf_we_o", wb_rf_we_o, e.rf_we);
    check_word("wb_rf_wdata_o", wb_rf_wdata_o, last_wdata);
    check_addr("wb_rf_waddr_o", wb_rf_waddr_o, last_waddr);
    check_word("wb_pc_o", wb_pc_o, pc_i);
    check_flag("wb_branch_taken_o", wb_branch_taken_o, e.exp_br);
    // Bubble follows, so the entry shows exactly once
    @(negedge clk);
    check_flag("wb_valid_o", wb_valid_o, 1'b0);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int err_before;
    void'($urandom(32'hd424aa10));
    errors         = 0;
    entries_failed = 0;
    last_wdata     = '0;
    last_waddr     = '0;
    rst_n          = 1'b0;
    instr_valid_i  = 1'b0;
    alu_op_i       = ex_pkg::ALU_ADD;
    operand_a_i    = '0;
    operand_b_i    = '0;
    operand_c_i    = '0;
    mul_en_i       = 1'b0;
    mul_op_i       = ex_pkg::MUL_LO;
    rf_we_i        = 1'b0;
    rf_waddr_i     = '0;
    pc_i           = '0;
    kill_i         = 1'b0;
    halt_i         = 1'b0;
    wb_ready_i     = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Reset state
    check_flag("wb_valid_o", wb_valid_o, 1'b0);
    check_flag("wb_rf_we_o", wb_rf_we_o, 1'b0);
    check_flag("wb_branch_taken_o", wb_branch_taken_o, 1'b0);
    check_word("wb_rf_wdata_o", wb_rf_wdata_o, '0);
    check_addr("wb_rf_waddr_o", wb_rf_waddr_o, '0);
    check_word("wb_pc_o", wb_pc_o, '0);
    $display("reset check: %s", (errors == 0) ? "ok" : "FAILED");
    if (errors != 0) entries_failed++;

    foreach (table_q[i]) begin
      err_before = errors;
      if (table_q[i].ctrl == CTRL_KILL) begin
        run_kill(table_q[i], i);
      end else begin
        if (table_q[i].ctrl == CTRL_HALT) begin
          // Held off by halt, then completes normally
          halt_i     = 1'b1;
          wb_ready_i = 1'b1;
          drive_entry(table_q[i], i);
          repeat (3) begin
            #1;
            check_flag("ex_valid_o", ex_valid_o, 1'b0);
            check_flag("ex_ready_o", ex_ready_o, 1'b0);
            @(negedge clk);
            check_flag("wb_valid_o", wb_valid_o, 1'b0);
          end
          halt_i = 1'b0;
        end
        run_normal(table_q[i], i);
      end
      if (errors != err_before) entries_failed++;
      $display("entry %0d %s: %s", i, table_q[i].op.name(),
               (errors == err_before) ? "ok" : "FAILED");
    end

    $display("entries run %0d, failed %0d, check errors %0d",
             table_q.size() + 1, entries_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table length and the worst multiply
  initial begin
    wait (table_ready);
    #((16 + table_q.size() * (`EX_MUL_STEPS + MAX_STALL + 8)) * 20);
    $display("Watchdog expired before the table finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: files.f
+incdir+logic
logic/ex_pkg.sv
logic/ex_issue_if.sv
logic/ex_issue.sv
logic/ex_alu.sv
logic/ex_mult.sv
logic/ex_retire.sv
logic/ex_stage.sv
test/tb_ex_stage.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/ex_pkg.sv
      - logic/ex_issue_if.sv
      - logic/ex_issue.sv
      - logic/ex_alu.sv
      - logic/ex_mult.sv
      - logic/ex_retire.sv
      - logic/ex_stage.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_ex_stage.sv
